// File: source/hist_pkg.sv
// package with data widths, APB register map, window state enum and pixel, config and bin structs
package hist_pkg;

    localparam int PIX_W      = 8;                     // pixel value bits
    localparam int COLOR_W    = 2;                     // {line parity, pixel parity}
    localparam int BIN_ADDR_W = COLOR_W + PIX_W;       // color bits then pixel bits
    localparam int NUM_BINS   = 1 << BIN_ADDR_W;
    localparam int CNT_W      = 32;
    localparam int COORD_W    = 16;
    // bins occupy 0x800..0x17fc, one address bit above the 2 KB register page
    localparam int APB_ADDR_W = 13;
    localparam int APB_DATA_W = 32;

    localparam logic [APB_ADDR_W-1:0] REG_CTRL     = 'h000;  // [0] enable
    localparam logic [APB_ADDR_W-1:0] REG_LEFT_TOP = 'h004;  // {top, left}
    localparam logic [APB_ADDR_W-1:0] REG_SIZE     = 'h008;  // {height-1, width-1}
    localparam logic [APB_ADDR_W-1:0] REG_STATUS   = 'h00c;  // [0] done, write 1 to ack
    localparam logic [APB_ADDR_W-1:0] BIN_BASE     = 'h800;  // bin n at BIN_BASE + 4n

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_TOP      = 2'd1,
        ST_IN_WIN   = 2'd2,
        ST_WAIT_ACK = 2'd3
    } win_state_e;

    typedef struct packed {
        logic             sof;
        logic             hact;
        logic [PIX_W-1:0] data;
    } pix_t;

    typedef struct packed {
        logic [COORD_W-1:0] left;
        logic [COORD_W-1:0] top;
        logic [COORD_W-1:0] width_m1;
        logic [COORD_W-1:0] height_m1;
    } win_cfg_t;

    typedef struct packed {
        logic                  valid;
        logic [BIN_ADDR_W-1:0] addr;
    } bin_inc_t;

    typedef struct packed {
        logic                  valid;
        logic [BIN_ADDR_W-1:0] addr;
    } bin_rd_req_t;

endpackage

// File: source/hist_window.sv
// Bayer color tracking, window of interest counters, frame FSM and bin increments
`timescale 1ns/1ps

module hist_window (
    input  logic               pclk,
    input  logic               hist_rst_pclk,
    input  hist_pkg::pix_t     pix_i,
    input  hist_pkg::win_cfg_t cfg_i,
    input  logic               en_i,
    input  logic               ack_i,
    output hist_pkg::bin_inc_t inc_o,
    output logic               frame_done_o
);
    hist_pkg::win_state_e            state_q;
    logic [hist_pkg::COORD_W-1:0]    vcnt_q;      // lines left in margin or window
    logic [hist_pkg::COORD_W-1:0]    hcnt_q;      // pixels left in margin or window
    logic                            hact_d;
    logic                            line_end;
    logic                            start;
    logic                            line_par_q;
    logic                            pix_par_q;
    logic [hist_pkg::COLOR_W-1:0]    color;
    logic                            h_pre_q;     // left of the window
    logic                            h_in_q;      // inside window horizontally
    logic                            h_win;
    logic                            v_win;
    logic                            inc_valid_q;
    logic [hist_pkg::BIN_ADDR_W-1:0] inc_addr_q;
    logic                            frame_done_q;

    assign line_end = hact_d && !pix_i.hact;
    assign start    = pix_i.sof && en_i && (state_q == hist_pkg::ST_IDLE);
    assign color    = pix_i.sof ? '0 : {line_par_q, pix_par_q};  // sof beat is line 0, pixel 0
    assign h_win    = h_in_q || (h_pre_q && (hcnt_q == '0));
    assign v_win    = pix_i.sof ? (start && (cfg_i.top == '0))
                                : (state_q == hist_pkg::ST_IN_WIN);

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hact_d     <= 1'b0;
            line_par_q <= 1'b0;
            pix_par_q  <= 1'b0;
        end else begin
            hact_d <= pix_i.hact;
            if (pix_i.sof) begin
                line_par_q <= 1'b0;
                pix_par_q  <= pix_i.hact;  // sof may carry the first pixel
            end else if (pix_i.hact) begin
                pix_par_q <= !pix_par_q;
            end else begin
                pix_par_q <= 1'b0;         // each line starts on an even pixel
                if (hact_d) begin
                    line_par_q <= !line_par_q;
                end
            end
        end
    end

    // count off the left margin, then width_m1 + 1 window pixels
    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            h_pre_q <= 1'b0;
            h_in_q  <= 1'b0;
            hcnt_q  <= '0;
        end else if (!pix_i.hact) begin
            h_pre_q <= 1'b1;
            h_in_q  <= 1'b0;
            hcnt_q  <= cfg_i.left;
        end else if (h_pre_q) begin
            if (hcnt_q == '0) begin
                h_pre_q <= 1'b0;
                h_in_q  <= (cfg_i.width_m1 != '0);
                hcnt_q  <= cfg_i.width_m1 - 1'b1;   // first window pixel is this beat
            end else begin
                hcnt_q <= hcnt_q - 1'b1;
            end
        end else if (h_in_q) begin
            if (hcnt_q == '0) begin
                h_in_q <= 1'b0;
            end else begin
                hcnt_q <= hcnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            state_q      <= hist_pkg::ST_IDLE;
            vcnt_q       <= '0;
            frame_done_q <= 1'b0;
        end else begin
            frame_done_q <= 1'b0;
            if (start) begin
                if (cfg_i.top == '0) begin
                    state_q <= hist_pkg::ST_IN_WIN;
                    vcnt_q  <= cfg_i.height_m1;
                end else begin
                    state_q <= hist_pkg::ST_TOP;
                    vcnt_q  <= cfg_i.top - 1'b1;
                end
            end else if (pix_i.sof && (state_q != hist_pkg::ST_WAIT_ACK)) begin
                state_q <= hist_pkg::ST_IDLE;   // disabled at frame boundary
            end else begin
                case (state_q)
                    hist_pkg::ST_TOP: begin
                        if (line_end && (vcnt_q == '0)) begin
                            state_q <= hist_pkg::ST_IN_WIN;
                            vcnt_q  <= cfg_i.height_m1;
                        end else if (line_end) begin
                            vcnt_q <= vcnt_q - 1'b1;
                        end
                    end
                    hist_pkg::ST_IN_WIN: begin
                        if (line_end && (vcnt_q == '0)) begin
                            state_q      <= hist_pkg::ST_WAIT_ACK;
                            frame_done_q <= 1'b1;  // last window line just ended
                        end else if (line_end) begin
                            vcnt_q <= vcnt_q - 1'b1;
                        end
                    end
                    hist_pkg::ST_WAIT_ACK: begin
                        if (ack_i) begin
                            state_q <= hist_pkg::ST_IDLE;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            inc_valid_q <= 1'b0;
        end else begin
            inc_valid_q <= pix_i.hact && h_win && v_win;
        end
    end

    always_ff @(posedge pclk) begin
        inc_addr_q <= {color, pix_i.data};
    end

    assign inc_o        = '{valid: inc_valid_q, addr: inc_addr_q};
    assign frame_done_o = frame_done_q;

endmodule

// File: source/hist_bin_ram.sv
// bin count memory with read-modify-write pipeline, forwarding and read-and-clear
`timescale 1ns/1ps

module hist_bin_ram (
    input  logic                        pclk,
    input  logic                        hist_rst_pclk,
    input  hist_pkg::bin_inc_t          inc_i,
    input  hist_pkg::bin_rd_req_t       rd_req_i,
    output logic [hist_pkg::CNT_W-1:0]  rd_data_o
);
    logic [hist_pkg::CNT_W-1:0]      mem [hist_pkg::NUM_BINS];
    logic [hist_pkg::NUM_BINS-1:0]   bin_vld_q;   // bin written since last clear
    logic                            s1_vld_q;
    logic [hist_pkg::BIN_ADDR_W-1:0] s1_addr_q;
    logic [hist_pkg::CNT_W-1:0]      s1_cnt_q;    // count fetched from memory
    logic                            s2_vld_q;
    logic [hist_pkg::BIN_ADDR_W-1:0] s2_addr_q;
    logic [hist_pkg::CNT_W-1:0]      s2_cnt_q;    // count written last cycle
    logic                            fwd;
    logic [hist_pkg::CNT_W-1:0]      base;
    logic [hist_pkg::CNT_W-1:0]      upd;
    logic [hist_pkg::CNT_W-1:0]      rd_data_q;

    // the fetch of s1 missed the write of s2 when both hit the same bin
    assign fwd  = s2_vld_q && (s2_addr_q == s1_addr_q);
    assign base = fwd ? s2_cnt_q : s1_cnt_q;
    assign upd  = base + 1'b1;

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
        end else begin
            s1_vld_q <= inc_i.valid;
            s2_vld_q <= s1_vld_q;
        end
    end

    always_ff @(posedge pclk) begin
        s1_addr_q <= inc_i.addr;
        s1_cnt_q  <= bin_vld_q[inc_i.addr] ? mem[inc_i.addr] : '0;
        s2_addr_q <= s1_addr_q;
        s2_cnt_q  <= upd;
    end

    // write back two cycles after the increment arrives
    always_ff @(posedge pclk) begin
        if (s1_vld_q) begin
            mem[s1_addr_q] <= upd;
        end
    end

    // reset clears every bin at once, a read clears one bin
    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            bin_vld_q <= '0;
        end else begin
            if (rd_req_i.valid) begin
                bin_vld_q[rd_req_i.addr] <= 1'b0;
            end
            if (s1_vld_q) begin
                bin_vld_q[s1_addr_q] <= 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (rd_req_i.valid) begin
            rd_data_q <= bin_vld_q[rd_req_i.addr] ? mem[rd_req_i.addr] : '0;
        end
    end

    assign rd_data_o = rd_data_q;  // count before the clear

endmodule

// File: source/hist_apb_port.sv
// APB slave with window config, enable, done status and bin readout
`timescale 1ns/1ps

module hist_apb_port (
    input  logic                             pclk,
    input  logic                             hist_rst_pclk,
    input  logic                             psel_i,
    input  logic                             penable_i,
    input  logic                             pwrite_i,
    input  logic [hist_pkg::APB_ADDR_W-1:0]  paddr_i,
    input  logic [hist_pkg::APB_DATA_W-1:0]  pwdata_i,
    output logic [hist_pkg::APB_DATA_W-1:0]  prdata_o,
    output logic                             pready_o,
    output logic                             pslverr_o,
    input  logic                             frame_done_i,
    input  logic [hist_pkg::CNT_W-1:0]       rd_data_i,
    output hist_pkg::win_cfg_t               cfg_o,
    output logic                             en_o,
    output logic                             ack_o,
    output hist_pkg::bin_rd_req_t            rd_req_o
);
    localparam int CW = hist_pkg::COORD_W;

    logic                            access;
    logic                            bin_sel;
    logic                            reg_wr;
    logic                            ack_wr;
    logic                            rd_issue;
    logic                            bin_wait_q;  // second access cycle of a bin read
    logic [hist_pkg::APB_ADDR_W-1:0] bin_off;
    logic                            en_q;
    logic                            done_q;
    logic                            ack_q;
    hist_pkg::win_cfg_t              cfg_q;
    logic [hist_pkg::APB_DATA_W-1:0] reg_rdata;

    assign access   = psel_i && penable_i;
    assign bin_sel  = (paddr_i >= hist_pkg::BIN_BASE);
    assign bin_off  = paddr_i - hist_pkg::BIN_BASE;
    assign rd_issue = access && bin_sel && !pwrite_i && !bin_wait_q;
    assign reg_wr   = access && pwrite_i && !bin_sel;
    assign ack_wr   = reg_wr && (paddr_i == hist_pkg::REG_STATUS) && pwdata_i[0];

    // registers and bin writes finish at once, bin reads take one wait state
    assign pready_o  = access && (!bin_sel || pwrite_i || bin_wait_q);
    assign pslverr_o = 1'b0;

    assign rd_req_o = '{valid: rd_issue, addr: bin_off[hist_pkg::BIN_ADDR_W+1:2]};

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            bin_wait_q <= 1'b0;
        end else begin
            bin_wait_q <= rd_issue;
        end
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            en_q   <= 1'b0;
            done_q <= 1'b0;
            ack_q  <= 1'b0;
            cfg_q  <= '0;
        end else begin
            ack_q <= ack_wr;
            if (reg_wr) begin
                case (paddr_i)
                    hist_pkg::REG_CTRL: begin
                        en_q <= pwdata_i[0];
                    end
                    hist_pkg::REG_LEFT_TOP: begin
                        cfg_q.left <= pwdata_i[CW-1:0];
                        cfg_q.top  <= pwdata_i[2*CW-1:CW];
                    end
                    hist_pkg::REG_SIZE: begin
                        cfg_q.width_m1  <= pwdata_i[CW-1:0];
                        cfg_q.height_m1 <= pwdata_i[2*CW-1:CW];
                    end
                    default: ;
                endcase
            end
            if (frame_done_i) begin
                done_q <= 1'b1;
            end else if (ack_wr) begin
                done_q <= 1'b0;
            end
        end
    end

    always_comb begin
        reg_rdata = '0;
        case (paddr_i)
            hist_pkg::REG_CTRL:     reg_rdata[0] = en_q;
            hist_pkg::REG_LEFT_TOP: reg_rdata = {cfg_q.top, cfg_q.left};
            hist_pkg::REG_SIZE:     reg_rdata = {cfg_q.height_m1, cfg_q.width_m1};
            hist_pkg::REG_STATUS:   reg_rdata[0] = done_q;
            default:                reg_rdata = '0;
        endcase
    end

    assign prdata_o = bin_wait_q ? rd_data_i : reg_rdata;
    assign cfg_o    = cfg_q;
    assign en_o     = en_q;
    assign ack_o    = ack_q;  // window leaves ST_WAIT_ACK on this pulse

endmodule

// File: source/hist_top.sv
// histogram top level with window tracker, bin memory and APB port
`timescale 1ns/1ps

module hist_top (
    input  logic                             pclk,
    input  logic                             hist_rst_pclk,
    input  hist_pkg::pix_t                   pix_i,
    input  logic                             psel_i,
    input  logic                             penable_i,
    input  logic                             pwrite_i,
    input  logic [hist_pkg::APB_ADDR_W-1:0]  paddr_i,
    input  logic [hist_pkg::APB_DATA_W-1:0]  pwdata_i,
    output logic [hist_pkg::APB_DATA_W-1:0]  prdata_o,
    output logic                             pready_o,
    output logic                             pslverr_o
);
    hist_pkg::win_cfg_t          cfg;
    logic                        en;
    logic                        ack;
    logic                        frame_done;
    hist_pkg::bin_inc_t          inc;
    hist_pkg::bin_rd_req_t       rd_req;
    logic [hist_pkg::CNT_W-1:0]  rd_data;

    hist_window i_window (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .pix_i         (pix_i),
        .cfg_i         (cfg),
        .en_i          (en),
        .ack_i         (ack),
        .inc_o         (inc),
        .frame_done_o  (frame_done)
    );

    hist_bin_ram i_bin_ram (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .inc_i         (inc),
        .rd_req_i      (rd_req),
        .rd_data_o     (rd_data)     // one cycle after rd_req
    );

    hist_apb_port i_apb_port (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .frame_done_i  (frame_done),
        .rd_data_i     (rd_data),
        .cfg_o         (cfg),
        .en_o          (en),
        .ack_o         (ack),
        .rd_req_o      (rd_req)
    );

endmodule

// File: bench/hist_clk_gen.sv
// testbench pixel clock and power-on reset pulse
`timescale 1ns/1ps

module hist_clk_gen (
    output logic pclk_o,
    output logic rst_o
);
    initial begin
        pclk_o = 1'b0;
        forever begin
            #50 pclk_o = ~pclk_o;   // 100 ns period
        end
    end

    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge pclk_o);   // held for 5 cycles
        #10 rst_o = 1'b0;
    end

endmodule

// File: bench/hist_assert.sv
// concurrent checks on APB wait states, slave error, increments and done pulse, and their bind
`timescale 1ns/1ps

module hist_assert (
    input logic                            pclk,
    input logic                            hist_rst_pclk,
    input logic                            psel_i,
    input logic                            penable_i,
    input logic                            pwrite_i,
    input logic [hist_pkg::APB_ADDR_W-1:0] paddr_i,
    input logic                            pready_i,
    input logic                            pslverr_i,
    input hist_pkg::bin_inc_t              inc_i,
    input logic                            frame_done_i,
    input hist_pkg::win_state_e            state_i
);
    int   fail_cnt = 0;   // number of failed assertions
    logic setup;
    logic reg_setup;
    logic bin_rd_setup;

    assign setup        = psel_i && !penable_i;
    assign reg_setup    = setup && (paddr_i < hist_pkg::BIN_BASE);
    assign bin_rd_setup = setup && !pwrite_i && (paddr_i >= hist_pkg::BIN_BASE);

    reg_no_wait: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        reg_setup |=> pready_i)
    else begin
        $error("register access did not complete in its first access cycle");
        fail_cnt++;
    end

    bin_one_wait: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        bin_rd_setup |=> !pready_i ##1 pready_i)
    else begin
        $error("bin read did not take exactly one wait state");
        fail_cnt++;
    end

    no_slverr: assert property (@(posedge pclk) disable iff (hist_rst_pclk) !pslverr_i)
    else begin
        $error("pslverr was raised");
        fail_cnt++;
    end

    no_inc_in_wait: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        !(inc_i.valid && (state_i == hist_pkg::ST_WAIT_ACK)))
    else begin
        $error("bin increment issued while waiting for the acknowledge");
        fail_cnt++;
    end

    done_one_cycle: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        frame_done_i |=> !frame_done_i)
    else begin
        $error("frame done pulse lasted longer than one cycle");
        fail_cnt++;
    end

endmodule

bind hist_top hist_assert i_assert (
    .pclk          (pclk),
    .hist_rst_pclk (hist_rst_pclk),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pready_i      (pready_o),
    .pslverr_i     (pslverr_o),
    .inc_i         (inc),
    .frame_done_i  (frame_done),
    .state_i       (i_window.state_q)
);

// File: bench/hist_tb.sv
// testbench top with APB and pixel drivers, reference histogram and six tests
`timescale 1ns/1ps

module hist_tb;
    logic                            pclk;
    logic                            hist_rst_pclk;
    hist_pkg::pix_t                  pix;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [hist_pkg::APB_ADDR_W-1:0] paddr;
    logic [hist_pkg::APB_DATA_W-1:0] pwdata;
    logic [hist_pkg::APB_DATA_W-1:0] prdata;
    logic                            pready;
    logic                            pslverr;
    logic [31:0]                     model [4][256];   // expected count per color, value
    int                              zero_vals [4] = '{0, 6, 8, 255};
    int                              seed = 42495;
    int                              cycle = 0;
    int                              errors = 0;
    int                              errs_at_start = 0;
    int                              tests = 0;
    int                              failed = 0;
    int                              win_left;
    int                              win_top;
    int                              win_w_m1;
    int                              win_h_m1;

    hist_clk_gen i_clk_gen (
        .pclk_o (pclk),
        .rst_o  (hist_rst_pclk)
    );

    hist_top i_dut (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .pix_i         (pix),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .paddr_i       (paddr),
        .pwdata_i      (pwdata),
        .prdata_o      (prdata),
        .pready_o      (pready),
        .pslverr_o     (pslverr)
    );

    always @(posedge pclk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act == exp) else begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [hist_pkg::APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waits;
        @(posedge pclk);
        #10;
        psel    = 1'b1;   // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge pclk);
        #10;
        penable = 1'b1;
        waits = 0;
        @(negedge pclk);  // pready settled mid-cycle
        while (!pready && waits < 4) begin
            @(negedge pclk);
            waits++;
        end
        if (!pready) begin
            $display("timeout: pready did not rise within 4 cycles at address 0x%0h", addr);
            errors++;
        end
        rdata = prdata;
        @(posedge pclk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [hist_pkg::APB_ADDR_W-1:0] addr,
                             input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [hist_pkg::APB_ADDR_W-1:0] addr,
                            output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'd0, data);
    endtask

    task automatic read_bin(input logic [1:0] c, input logic [7:0] v, output logic [31:0] d);
        apb_read(hist_pkg::BIN_BASE + {1'b0, c, v, 2'b00}, d);
    endtask

    task automatic set_window(input int l, input int t, input int w_m1, input int h_m1);
        win_left = l;
        win_top  = t;
        win_w_m1 = w_m1;
        win_h_m1 = h_m1;
        apb_write(hist_pkg::REG_LEFT_TOP, {t[15:0], l[15:0]});
        apb_write(hist_pkg::REG_SIZE, {h_m1[15:0], w_m1[15:0]});
    endtask

    task automatic blank_cycles(input int n);
        repeat (n) begin
            @(posedge pclk);
            #10;
            pix = '0;
        end
    endtask

    // with track set the reference histogram counts the in-window pixels
    task automatic send_frame(input int fw, input int fh, input logic rand_px,
                              input logic [7:0] flat_val, input logic track);
        logic [7:0] val;
        logic [1:0] color;
        int         r;
        for (int y = 0; y < fh; y++) begin
            blank_cycles(4);
            for (int x = 0; x < fw; x++) begin
                r     = $random(seed);
                val   = rand_px ? (r[7:0] & 8'h1f) : flat_val;   // narrow range, repeats
                color = {y[0], x[0]};
                @(posedge pclk);
                #10;
                pix.sof  = (x == 0) && (y == 0);
                pix.hact = 1'b1;
                pix.data = val;
                if (track && x >= win_left && x <= win_left + win_w_m1 &&
                    y >= win_top && y <= win_top + win_h_m1) begin
                    model[color][val] = model[color][val] + 1;
                end
            end
        end
        blank_cycles(4);
    endtask

    task automatic poll_done(output logic seen);
        logic [31:0] st;
        int          start;
        start = cycle;
        seen  = 1'b0;
        while (!seen && (cycle - start) < 200) begin
            apb_read(hist_pkg::REG_STATUS, st);
            seen = st[0];
        end
    endtask

    task automatic expect_done(input string name);
        logic seen;
        poll_done(seen);
        if (!seen) begin
            $display("timeout: done bit not set within 200 cycles in test %s", name);
            errors++;
        end
    endtask

    task automatic check_all_bins(input string name);
        logic [31:0] act;
        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v < 256; v++) begin
                read_bin(c[1:0], v[7:0], act);
                check_value($sformatf("%s bin %0d/%0d", name, c, v), model[c][v], act);
                model[c][v] = '0;   // the read cleared it
            end
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errs_at_start);
            failed++;
        end
        errs_at_start = errors;
    endtask

    initial begin
        logic [31:0] d;
        logic        seen;
        int          n;
        pix     = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v < 256; v++) begin
                model[c][v] = '0;
            end
        end
        n = 0;
        @(negedge pclk);
        while ((hist_rst_pclk !== 1'b0) && n < 20) begin
            @(negedge pclk);
            n++;
        end
        if (hist_rst_pclk !== 1'b0) begin
            $display("timeout: reset was never released");
            errors++;
        end
        errs_at_start = errors;

        apb_write(hist_pkg::REG_LEFT_TOP, 32'h0003_0005);
        apb_write(hist_pkg::REG_SIZE, 32'h0002_0004);
        apb_write(hist_pkg::REG_CTRL, 32'd1);
        apb_read(hist_pkg::REG_LEFT_TOP, d);
        check_value("readback left_top", 32'h0003_0005, d);
        apb_read(hist_pkg::REG_SIZE, d);
        check_value("readback size", 32'h0002_0004, d);
        apb_read(hist_pkg::REG_CTRL, d);
        check_value("readback ctrl", 32'd1, d);
        apb_read(hist_pkg::REG_STATUS, d);
        check_value("readback status", 32'd0, d);
        read_bin(2'd0, 8'd0, d);
        check_value("readback bin 0", 32'd0, d);
        end_test("readback");

        set_window(2, 1, 3, 3);
        send_frame(8, 6, 1'b0, 8'd7, 1'b0);   // 4x4 window, 2x2 pixels per color
        expect_done("flat frame");
        for (int c = 0; c < 4; c++) begin
            read_bin(c[1:0], 8'd7, d);
            check_value($sformatf("flat frame color %0d value 7", c), 32'd4, d);
            for (int k = 0; k < 4; k++) begin
                read_bin(c[1:0], zero_vals[k][7:0], d);
                check_value($sformatf("flat frame color %0d value %0d", c, zero_vals[k]),
                            32'd0, d);
            end
        end
        apb_write(hist_pkg::REG_STATUS, 32'd1);
        end_test("flat frame");

        set_window(1, 0, 11, 7);
        send_frame(16, 10, 1'b1, 8'd0, 1'b1);
        expect_done("random frame");
        check_all_bins("random frame");
        end_test("random frame");

        check_all_bins("read clear");
        end_test("read clear");

        send_frame(16, 10, 1'b1, 8'd0, 1'b0);   // done still set, so ignored
        apb_read(hist_pkg::REG_STATUS, d);
        check_value("wait ack done held", 32'd1, d);
        check_all_bins("wait ack ignored");
        apb_write(hist_pkg::REG_STATUS, 32'd1);
        apb_read(hist_pkg::REG_STATUS, d);
        check_value("wait ack done cleared", 32'd0, d);
        send_frame(16, 10, 1'b1, 8'd0, 1'b1);
        expect_done("wait ack");
        check_all_bins("wait ack counted");
        end_test("wait ack");

        apb_write(hist_pkg::REG_STATUS, 32'd1);
        apb_write(hist_pkg::REG_CTRL, 32'd0);
        send_frame(16, 10, 1'b1, 8'd0, 1'b0);
        poll_done(seen);   // runs into its timeout when disabled
        check_value("disable done", 32'd0, {31'd0, seen});
        check_all_bins("disable");
        end_test("disable");

        errors = errors + i_dut.i_assert.fail_cnt;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests, failed, errors, i_dut.i_assert.fail_cnt);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
source/hist_pkg.sv
source/hist_window.sv
source/hist_bin_ram.sv
source/hist_apb_port.sv
source/hist_top.sv
bench/hist_clk_gen.sv
bench/hist_assert.sv
bench/hist_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := hist_tb
FILELIST   := project.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_FLAGS  := +verilator+error+limit+100
PASS_MSG   := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
